// File: all.f
+incdir+.
ee_pkg.sv
ee_cmd_latch.sv
ee_frame_seq.sv
ee_bit_engine.sv
ee_ctrl_top.sv
tb_clock_gen.sv
tb_eeprom_model.sv
tb_ee_ctrl.sv

// File: ee_bit_engine.sv
`timescale 1ns/1ps
`include "ee_cfg.svh"

module ee_bit_engine (
    input  logic                CLK,
    input  logic                RESET,
    input  ee_pkg::ee_sym_t     sym,
    input  logic                sym_go,
    input  logic                sda_in,
    output logic                sym_done,
    output ee_pkg::ee_bit_res_t res,
    output logic                scl,
    output logic                sda_oe
);

    localparam int CW = ($clog2(`EE_QUARTER) < 1) ? 1 : $clog2(`EE_QUARTER);

    ee_pkg::ee_sym_t sym_q;
    logic            active;
    logic [CW-1:0]   cnt;
    logic [1:0]      qtr;
    logic [3:0]      bitn;     // 0..7 data, 8 ack
    logic            last_cyc;
    logic            last_qtr;
    logic            byte_sym;
    logic [1:0]      nxt_qtr;
    logic [3:0]      nxt_bit;
    logic [1:0]      drv_go;
    logic [1:0]      drv_nxt;

    // returns {scl, pull sda low} for one quarter
    function automatic logic [1:0] drive(
        input ee_pkg::ee_sym_e kind,
        input logic [7:0]      raw,
        input logic            mnack,
        input logic [3:0]      b,
        input logic [1:0]      q
    );
        logic hi;
        logic low;
        hi = (q == 2'd1) || (q == 2'd2);
        case (kind)
            ee_pkg::SYM_START:
            begin
                low = q[1];         // sda falls in the middle of scl high
                return {hi, low};
            end
            ee_pkg::SYM_STOP:
            begin
                low = ~q[1];        // sda rises while scl stays high
                return {q != 2'd0, low};
            end
            ee_pkg::SYM_TX:
            begin
                low = (b == 4'd8) ? 1'b0 : ~raw[3'd7 - b[2:0]];
                return {hi, low};
            end
            default:
            begin
                low = (b == 4'd8) && !mnack;
                return {hi, low};
            end
        endcase
    endfunction

    assign byte_sym = (sym_q.kind == ee_pkg::SYM_TX) || (sym_q.kind == ee_pkg::SYM_RX);
    assign last_cyc = (cnt == CW'(`EE_QUARTER - 1));
    assign last_qtr = (qtr == 2'd3) && (!byte_sym || (bitn == 4'd8));
    assign sym_done = active && last_cyc && last_qtr;

    assign nxt_qtr = qtr + 2'd1;
    assign nxt_bit = (qtr == 2'd3) ? bitn + 4'd1 : bitn;

    assign drv_go  = drive(sym.kind, sym.payload.raw, sym.master_nack, 4'd0, 2'd0);
    assign drv_nxt = drive(sym_q.kind, sym_q.payload.raw, sym_q.master_nack, nxt_bit, nxt_qtr);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active <= 1'b0;
            cnt    <= '0;
            qtr    <= 2'd0;
            bitn   <= 4'd0;
            scl    <= 1'b1;
            sda_oe <= 1'b0;
        end
        else if (sym_go)
        begin
            active <= 1'b1;
            cnt    <= '0;
            qtr    <= 2'd0;
            bitn   <= 4'd0;
            scl    <= drv_go[1];
            sda_oe <= drv_go[0];
        end
        else if (active)
        begin
            if (last_cyc)
            begin
                cnt <= '0;
                if (last_qtr)
                    active <= 1'b0;     // lines hold until the next symbol
                else
                begin
                    qtr    <= nxt_qtr;
                    bitn   <= nxt_bit;
                    scl    <= drv_nxt[1];
                    sda_oe <= drv_nxt[0];
                end
            end
            else
                cnt <= cnt + CW'(1);
        end
    end

    always_ff @(posedge CLK)
    begin
        if (sym_go)
            sym_q <= sym;
        // sample at the end of the first high quarter
        if (active && byte_sym && last_cyc && (qtr == 2'd1))
        begin
            if (bitn == 4'd8)
                res.ack_seen <= ~sda_in;
            else
                res.rx_byte <= {res.rx_byte[6:0], sda_in};  // msb first
        end
    end

endmodule

// File: ee_cfg.svh
`ifndef EE_CFG_SVH
`define EE_CFG_SVH

// clk cycles per quarter of an scl bit, 4 quarters per bit
`define EE_QUARTER 2

// fixed upper nibble of the control byte on 24c16 parts
`define EE_DEV_CODE 4'b1010

// 2k bytes, top 3 bits pick the block
`define EE_ADDR_W 11

`endif

// File: ee_cmd_latch.sv
`timescale 1ns/1ps
`include "ee_cfg.svh"

module ee_cmd_latch (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   wr,
    input  logic                   rd,
    input  logic [`EE_ADDR_W-1:0]  addr,
    input  logic [7:0]             wdata,
    input  logic                   cmd_take,
    output ee_pkg::ee_cmd_t        cmd,
    output logic                   cmd_valid,
    output logic                   busy
);

    ee_pkg::ee_cmd_t new_cmd;
    ee_pkg::ee_cmd_t pend_q;
    logic            pend_valid;
    logic            accept;

    always_comb
    begin
        new_cmd.rw        = ~wr;    // wr wins over rd
        new_cmd.block     = addr[`EE_ADDR_W-1 -: 3];
        new_cmd.word_addr = addr[7:0];
        new_cmd.wdata     = wdata;
    end

    // strobes while the slot is full are dropped
    assign accept = (wr | rd) & ~pend_valid;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            pend_valid <= 1'b0;
        else if (accept)
            pend_valid <= 1'b1;
        else if (cmd_take)
            pend_valid <= 1'b0;
    end

    // cmd is the current command, stable for the whole frame
    always_ff @(posedge CLK)
    begin
        if (accept)
            pend_q <= new_cmd;
        if (cmd_take)
            cmd <= pend_q;
    end

    assign cmd_valid = pend_valid;
    assign busy      = pend_valid;

endmodule

// File: ee_ctrl_top.sv
`timescale 1ns/1ps
`include "ee_cfg.svh"

module ee_ctrl_top (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [7:0]            wdata,
    output logic [7:0]            rdata,
    output logic                  ack,
    output logic                  nack_err,
    output logic                  busy,
    output logic                  scl,
    inout  wire                   sda
);

    ee_pkg::ee_cmd_t     cmd;
    logic                cmd_valid;
    logic                cmd_take;
    ee_pkg::ee_sym_t     sym;
    logic                sym_go;
    logic                sym_done;
    ee_pkg::ee_bit_res_t res;
    logic                sda_oe;
    logic                sda_in;

    // open drain, pull-up sits outside
    assign sda    = sda_oe ? 1'b0 : 1'bz;
    assign sda_in = sda;

    ee_cmd_latch u_cmd_latch (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .cmd_take  (cmd_take),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .busy      (busy)
    );

    ee_frame_seq u_frame_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .sym_done  (sym_done),
        .res       (res),
        .cmd_take  (cmd_take),
        .sym       (sym),
        .sym_go    (sym_go),
        .ack       (ack),
        .rdata     (rdata),
        .nack_err  (nack_err)
    );

    ee_bit_engine u_bit_engine (
        .CLK      (CLK),
        .RESET    (RESET),
        .sym      (sym),
        .sym_go   (sym_go),
        .sda_in   (sda_in),
        .sym_done (sym_done),
        .res      (res),
        .scl      (scl),
        .sda_oe   (sda_oe)
    );

endmodule

// File: ee_frame_seq.sv
`timescale 1ns/1ps
`include "ee_cfg.svh"

module ee_frame_seq (
    input  logic                CLK,
    input  logic                RESET,
    input  ee_pkg::ee_cmd_t     cmd,
    input  logic                cmd_valid,
    input  logic                sym_done,
    input  ee_pkg::ee_bit_res_t res,
    output logic                cmd_take,
    output ee_pkg::ee_sym_t     sym,
    output logic                sym_go,
    output logic                ack,
    output logic [7:0]          rdata,
    output logic                nack_err
);

    // one-hot states named for the symbol in flight
    localparam logic [8:0] ST_IDLE   = 9'b0_0000_0001;
    localparam logic [8:0] ST_START  = 9'b0_0000_0010;
    localparam logic [8:0] ST_CTRL_W = 9'b0_0000_0100;
    localparam logic [8:0] ST_ADDR   = 9'b0_0000_1000;
    localparam logic [8:0] ST_DATA   = 9'b0_0001_0000;
    localparam logic [8:0] ST_RSTART = 9'b0_0010_0000;
    localparam logic [8:0] ST_CTRL_R = 9'b0_0100_0000;
    localparam logic [8:0] ST_RECV   = 9'b0_1000_0000;
    localparam logic [8:0] ST_STOP   = 9'b1_0000_0000;

    logic [8:0]       state_q;
    logic [8:0]       state_d;
    ee_pkg::ee_sym_t  sym_d;
    ee_pkg::ee_byte_u ctrl_u;
    logic             go_d;
    logic             tx_nack;
    logic             stop_done;
    logic             err_q;

    function automatic ee_pkg::ee_sym_t mk_sym(
        input ee_pkg::ee_sym_e  kind,
        input ee_pkg::ee_byte_u payload,
        input logic             mnack
    );
        ee_pkg::ee_sym_t s;
        s.kind        = kind;
        s.payload     = payload;
        s.master_nack = mnack;
        return s;
    endfunction

    always_comb
    begin
        ctrl_u.ctrl.dev_code = `EE_DEV_CODE;
        ctrl_u.ctrl.block    = cmd.block;
        ctrl_u.ctrl.rw       = (state_q == ST_RSTART);  // read only after the repeated start
    end

    assign tx_nack   = sym_done && (sym.kind == ee_pkg::SYM_TX) && !res.ack_seen;
    assign stop_done = sym_done && (state_q == ST_STOP);

    always_comb
    begin
        state_d  = state_q;
        sym_d    = sym;
        go_d     = 1'b0;
        cmd_take = 1'b0;
        if (state_q == ST_IDLE)
        begin
            if (cmd_valid)
            begin
                cmd_take = 1'b1;
                state_d  = ST_START;
                sym_d    = mk_sym(ee_pkg::SYM_START, '0, 1'b0);
                go_d     = 1'b1;
            end
        end
        else if (sym_done)
        begin
            go_d = 1'b1;
            if (tx_nack)
            begin
                // slave gave no ack so the frame closes now
                state_d = ST_STOP;
                sym_d   = mk_sym(ee_pkg::SYM_STOP, '0, 1'b0);
            end
            else
            begin
                case (state_q)
                    ST_START:
                    begin
                        state_d = ST_CTRL_W;
                        sym_d   = mk_sym(ee_pkg::SYM_TX, ctrl_u, 1'b0);
                    end
                    ST_CTRL_W:
                    begin
                        state_d = ST_ADDR;
                        sym_d   = mk_sym(ee_pkg::SYM_TX, ee_pkg::ee_byte_u'(cmd.word_addr), 1'b0);
                    end
                    ST_ADDR:
                    begin
                        if (cmd.rw)
                        begin
                            state_d = ST_RSTART;
                            sym_d   = mk_sym(ee_pkg::SYM_START, '0, 1'b0);
                        end
                        else
                        begin
                            state_d = ST_DATA;
                            sym_d   = mk_sym(ee_pkg::SYM_TX, ee_pkg::ee_byte_u'(cmd.wdata), 1'b0);
                        end
                    end
                    ST_RSTART:
                    begin
                        state_d = ST_CTRL_R;
                        sym_d   = mk_sym(ee_pkg::SYM_TX, ctrl_u, 1'b0);
                    end
                    ST_CTRL_R:
                    begin
                        state_d = ST_RECV;
                        sym_d   = mk_sym(ee_pkg::SYM_RX, '0, 1'b1);  // single byte with master nack
                    end
                    ST_DATA, ST_RECV:
                    begin
                        state_d = ST_STOP;
                        sym_d   = mk_sym(ee_pkg::SYM_STOP, '0, 1'b0);
                    end
                    default:
                    begin
                        state_d = ST_IDLE;  // stop finished
                        go_d    = 1'b0;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state_q  <= ST_IDLE;
            sym_go   <= 1'b0;
            ack      <= 1'b0;
            nack_err <= 1'b0;
            err_q    <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            sym_go  <= go_d;
            ack     <= stop_done;
            if (cmd_take)
                err_q <= 1'b0;
            else if (tx_nack)
                err_q <= 1'b1;
            if (stop_done)
                nack_err <= err_q;
        end
    end

    always_ff @(posedge CLK)
    begin
        sym <= sym_d;
        if (stop_done && cmd.rw && !err_q)
            rdata <= res.rx_byte;  // failed reads keep the old byte
    end

endmodule

// File: ee_pkg.sv
package ee_pkg;

    // command as captured from the host strobe
    typedef struct packed {
        logic       rw;         // 1 = read
        logic [2:0] block;
        logic [7:0] word_addr;
        logic [7:0] wdata;
    } ee_cmd_t;

    // first byte of a frame
    typedef struct packed {
        logic [3:0] dev_code;
        logic [2:0] block;
        logic       rw;
    } ee_ctrl_byte_t;

    // seq fills ctrl, bit engine shifts raw
    typedef union packed {
        ee_ctrl_byte_t ctrl;
        logic [7:0]    raw;
    } ee_byte_u;

    // start while the bus is held gives a repeated start
    typedef enum logic [1:0] {
        SYM_START,
        SYM_STOP,
        SYM_TX,
        SYM_RX
    } ee_sym_e;

    typedef struct packed {
        ee_sym_e  kind;
        ee_byte_u payload;
        logic     master_nack;  // no master ack after SYM_RX
    } ee_sym_t;

    typedef struct packed {
        logic       ack_seen;   // sda low in ninth bit of SYM_TX
        logic [7:0] rx_byte;
    } ee_bit_res_t;

endpackage

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic CLK,
    output logic RESET
);

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;     // 40 ns period
    end

    initial
    begin
        RESET = 1'b1;
        repeat (2) @(posedge CLK);
        #2;
        RESET = 1'b0;
    end

endmodule

// File: tb_ee_ctrl.sv
`timescale 1ns/1ps
`include "ee_cfg.svh"

module tb_ee_ctrl;

    typedef struct packed {
        logic                  op;         // 1 = read
        logic [`EE_ADDR_W-1:0] addr;
        logic [7:0]            wdata;
        logic [7:0]            exp_rdata;
        logic                  chk_rdata;  // rdata has a known value by then
        logic                  exp_nack;
        logic                  ovl;        // strobed while the entry before runs
    } test_entry_t;

    localparam int CLK_NS    = 40;
    // random read is 156 quarters plus turnaround cycles
    localparam int OP_CYCLES = 156 * `EE_QUARTER + 32;

    logic                  CLK;
    logic                  RESET;
    logic                  wr;
    logic                  rd;
    logic [`EE_ADDR_W-1:0] addr;
    logic [7:0]            wdata;
    logic [7:0]            rdata;
    logic                  ack;
    logic                  nack_err;
    logic                  busy;
    logic                  scl;
    wire                   sda;

    test_entry_t tests [0:31];
    int          n_tests;
    logic [7:0]  shadow [0:2047];
    logic [7:0]  last_rd;
    logic        last_rd_ok;
    logic        table_ready;
    int          passed;
    int          failed;

    pullup (sda);

    tb_clock_gen clk_gen (
        .CLK   (CLK),
        .RESET (RESET)
    );

    ee_ctrl_top dut (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .ack      (ack),
        .nack_err (nack_err),
        .busy     (busy),
        .scl      (scl),
        .sda      (sda)
    );

    tb_eeprom_model eeprom (
        .scl (scl),
        .sda (sda)
    );

    task automatic add_entry(input logic op, input logic [`EE_ADDR_W-1:0] a, input logic ovl);
        test_entry_t t;
        logic [31:0] rnd;
        rnd        = $urandom;
        t.op       = op;
        t.addr     = a;
        t.wdata    = op ? 8'h00 : rnd[7:0];
        t.ovl      = ovl;
        t.exp_nack = (a[`EE_ADDR_W-1 -: 3] == 3'd7);
        if (!t.exp_nack && op)
        begin
            last_rd    = shadow[a];
            last_rd_ok = 1'b1;
        end
        else if (!t.exp_nack)
            shadow[a] = t.wdata;
        t.exp_rdata    = last_rd;   // failed reads and writes leave rdata alone
        t.chk_rdata    = last_rd_ok;
        tests[n_tests] = t;
        n_tests        = n_tests + 1;
    endtask

    task automatic build_table();
        for (int k = 0; k < 2048; k++)
            shadow[k] = 8'hff;
        add_entry(1'b0, 11'h005, 1'b0);
        add_entry(1'b1, 11'h005, 1'b0);
        add_entry(1'b0, 11'h2c7, 1'b0);
        add_entry(1'b1, 11'h2c7, 1'b0);
        add_entry(1'b0, 11'h6fe, 1'b0);
        add_entry(1'b1, 11'h6fe, 1'b0);
        add_entry(1'b0, 11'h0ff, 1'b0);
        add_entry(1'b1, 11'h0ff, 1'b0);
        add_entry(1'b1, 11'h345, 1'b0);     // never written
        add_entry(1'b0, 11'h042, 1'b0);     // same word address in blocks 0 2 6
        add_entry(1'b0, 11'h242, 1'b0);
        add_entry(1'b0, 11'h642, 1'b0);
        add_entry(1'b1, 11'h042, 1'b0);
        add_entry(1'b1, 11'h242, 1'b0);
        add_entry(1'b1, 11'h642, 1'b0);
        add_entry(1'b0, 11'h742, 1'b0);     // block 7
        add_entry(1'b1, 11'h742, 1'b0);
        add_entry(1'b1, 11'h042, 1'b0);
        add_entry(1'b0, 11'h155, 1'b0);
        add_entry(1'b1, 11'h155, 1'b1);
        add_entry(1'b1, 11'h155, 1'b0);
        add_entry(1'b1, 11'h2c7, 1'b0);
        add_entry(1'b0, 11'h2c7, 1'b1);
        add_entry(1'b1, 11'h2c7, 1'b0);
    endtask

    task automatic strobe(input logic op, input logic [`EE_ADDR_W-1:0] a, input logic [7:0] d);
        @(posedge CLK);
        #2;
        wr    = ~op;
        rd    = op;
        addr  = a;
        wdata = d;
        @(posedge CLK);
        #2;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_ack();
        @(negedge CLK);
        while (ack !== 1'b1)
            @(negedge CLK);
    endtask

    task automatic finish_test(input string label, input logic ok);
        if (ok)
        begin
            passed = passed + 1;
            $display("%s: ok", label);
        end
        else
        begin
            failed = failed + 1;
            $display("%s: failed", label);
        end
    endtask

    // called in the ack cycle while rdata and nack_err are valid
    task automatic check_entry(input int idx);
        test_entry_t t;
        logic        ok;
        t  = tests[idx];
        ok = 1'b1;
        if (nack_err !== t.exp_nack)
        begin
            $display("Mismatch at %0t: entry %0d nack_err %b, expected %b",
                     $time, idx, nack_err, t.exp_nack);
            ok = 1'b0;
        end
        if (t.chk_rdata && (rdata !== t.exp_rdata))
        begin
            $display("Mismatch at %0t: entry %0d rdata %h, expected %h",
                     $time, idx, rdata, t.exp_rdata);
            ok = 1'b0;
        end
        finish_test($sformatf("entry %0d %s addr %h", idx, t.op ? "read" : "write", t.addr), ok);
    endtask

    initial
    begin : watchdog
        int limit_ns;
        wait (table_ready === 1'b1);
        limit_ns = (n_tests * 2 * OP_CYCLES + 8) * CLK_NS;
        #(limit_ns);
        $display("run timed out after %0d ns, an operation never finished", limit_ns);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin : main
        int          i;
        logic        grouped;
        logic        ok;
        logic        busy_ok;
        logic        extra_ack;
        logic [31:0] rnd;
        test_entry_t cur;
        test_entry_t nxt;

        wr          = 1'b0;
        rd          = 1'b0;
        addr        = '0;
        wdata       = 8'h00;
        table_ready = 1'b0;
        passed      = 0;
        failed      = 0;
        n_tests     = 0;
        last_rd     = 8'h00;
        last_rd_ok  = 1'b0;
        rnd         = $urandom(32'hf553946f);
        build_table();
        table_ready = 1'b1;

        @(negedge RESET);
        @(negedge CLK);
        ok = (scl === 1'b1) && (sda === 1'b1) && (ack === 1'b0) && (busy === 1'b0)
             && (nack_err === 1'b0);
        if (!ok)
            $display("Mismatch at %0t: after reset scl %b sda %b ack %b busy %b nack_err %b",
                     $time, scl, sda, ack, busy, nack_err);
        finish_test("reset state", ok);

        i = 0;
        while (i < n_tests)
        begin
            cur     = tests[i];
            grouped = 1'b0;
            if (i + 1 < n_tests)
            begin
                nxt     = tests[i + 1];
                grouped = nxt.ovl;
            end
            strobe(cur.op, cur.addr, cur.wdata);
            if (grouped)
            begin
                repeat (10) @(posedge CLK);
                strobe(nxt.op, nxt.addr, nxt.wdata);
                busy_ok = (busy === 1'b1);
                if (!busy_ok)
                    $display("Mismatch at %0t: busy %b after a strobe during a running op, expected 1",
                             $time, busy);
                // inverted final value that a later read would catch if accepted
                strobe(1'b0, cur.addr, ~shadow[cur.addr]);
            end
            wait_ack();
            check_entry(i);
            if (grouped)
            begin
                wait_ack();
                check_entry(i + 1);
                extra_ack = 1'b0;
                repeat (OP_CYCLES)
                begin
                    @(negedge CLK);
                    if (ack === 1'b1)
                        extra_ack = 1'b1;
                end
                if (extra_ack)
                    $display("an ack came from the strobe given while busy was high");
                finish_test($sformatf("strobe while busy, entries %0d and %0d", i, i + 1),
                            busy_ok && !extra_ack);
                i = i + 2;
            end
            else
                i = i + 1;
        end

        $display("%0d tests run, %0d passed, %0d failed", passed + failed, passed, failed);
        if (failed == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: tb_eeprom_model.sv
`timescale 1ns/1ps

module tb_eeprom_model (
    input  logic scl,
    inout  wire  sda
);

    localparam logic [2:0] PH_IDLE  = 3'd0;
    localparam logic [2:0] PH_CTRL  = 3'd1;
    localparam logic [2:0] PH_ADDR  = 3'd2;
    localparam logic [2:0] PH_WDATA = 3'd3;
    localparam logic [2:0] PH_SEND  = 3'd4;

    logic [7:0] mem [0:2047];
    logic [2:0] phase;
    logic [3:0] nbits;      // bits clocked in this byte
    logic       in_ack;     // ninth bit in progress
    logic [7:0] shift;
    logic [7:0] out_byte;
    logic [2:0] blk;
    logic [7:0] ptr;
    logic       rw;
    logic       master_ack;
    logic       pull_low;
    logic       scl_q;
    logic       sda_q;
    logic       scl_now;
    logic       sda_now;

    assign sda = pull_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hff;
        phase      = PH_IDLE;
        nbits      = 4'd0;
        in_ack     = 1'b0;
        shift      = 8'h00;
        out_byte   = 8'hff;
        blk        = 3'd0;
        ptr        = 8'h00;
        rw         = 1'b0;
        master_ack = 1'b0;
        pull_low   = 1'b0;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
    end

    // data changes while scl is low, so the model only moves sda here
    task scl_fall();
        if (phase != PH_IDLE)
        begin
            if (in_ack)
            begin
                in_ack   = 1'b0;
                nbits    = 4'd0;
                pull_low = 1'b0;
                case (phase)
                    PH_CTRL:
                        phase = rw ? PH_SEND : PH_ADDR;
                    PH_ADDR:
                        phase = PH_WDATA;
                    PH_SEND:
                    begin
                        ptr = ptr + 8'd1;
                        if (!master_ack)
                            phase = PH_IDLE;   // master nack ends the read
                    end
                    default:
                        phase = PH_IDLE;       // single byte writes only
                endcase
                if (phase == PH_SEND)
                begin
                    out_byte = mem[{blk, ptr}];
                    pull_low = ~out_byte[7];
                end
            end
            else if (nbits == 4'd8)
            begin
                in_ack = 1'b1;
                case (phase)
                    PH_CTRL:
                    begin
                        if (shift[7:4] == 4'b1010 && shift[3:1] != 3'd7)
                        begin
                            blk      = shift[3:1];
                            rw       = shift[0];
                            pull_low = 1'b1;
                        end
                        else
                        begin
                            phase  = PH_IDLE;  // no part fitted on block 7
                            in_ack = 1'b0;
                        end
                    end
                    PH_ADDR:
                    begin
                        ptr      = shift;
                        pull_low = 1'b1;
                    end
                    PH_WDATA:
                    begin
                        mem[{blk, ptr}] = shift;
                        pull_low        = 1'b1;
                    end
                    default:
                        pull_low = 1'b0;       // master owns the ack bit
                endcase
            end
            else if (phase == PH_SEND)
                pull_low = ~out_byte[3'd7 - nbits[2:0]];
        end
    endtask

    always @(scl or sda)
    begin
        scl_now = (scl === 1'b1);
        sda_now = (sda !== 1'b0);
        if (scl_q && scl_now && (sda_q != sda_now))
        begin
            // sda moved with scl high, start when falling, stop when rising
            phase    = sda_now ? PH_IDLE : PH_CTRL;
            nbits    = 4'd0;
            in_ack   = 1'b0;
            pull_low = 1'b0;
        end
        else if (!scl_q && scl_now)
        begin
            if (phase == PH_SEND && in_ack)
                master_ack = !sda_now;
            else if (phase != PH_IDLE && !in_ack)
            begin
                shift = {shift[6:0], sda_now};
                nbits = nbits + 4'd1;
            end
        end
        else if (scl_q && !scl_now)
            scl_fall();
        scl_q = scl_now;
        sda_q = sda_now;
    end

endmodule
